/* Makefile */
# Verilator build and run of the trace-driven testbench

VERILATOR ?= verilator
TOP       ?= soc_top_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from searching the simulation output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // master request, held stable from stb until ack
    typedef struct packed {
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } bus_req_t;

    // slave response, dat valid with ack
    typedef struct packed {
        logic  ack;
        data_t dat;
    } bus_rsp_t;

    // byte RAM
    localparam int RAM_DEPTH      = 4096;
    localparam int RAM_ADDR_WIDTH = $clog2(RAM_DEPTH);

    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

`default_nettype wire

/* common/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // 0xFFFFF800 - 0xFFFFFFFF is the I/O window
    localparam logic [20:0] IO_BASE_HI = 21'h1F_FFFF;

    typedef logic [2:0] page_t;  // adr[10:8] inside the window

    localparam page_t TIMER_PAGE = 3'd5;  // all other pages go to the port

    // timer registers on adr[1:0]
    localparam logic [1:0] TMR_CTRL      = 2'd0;
    localparam logic [1:0] TMR_STATUS    = 2'd1;
    localparam logic [1:0] TMR_RELOAD_LO = 2'd2;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd3;

    typedef logic [15:0] count_t;

    // reset stretch
    localparam int RESET_HOLD  = 16;
    localparam int HOLD_WIDTH  = $clog2(RESET_HOLD + 1);

    typedef logic [HOLD_WIDTH-1:0] hold_t;

    // port width
    localparam int GPIO_WIDTH = 8;

endpackage

`default_nettype wire

/* ram/ram_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_wb8 (
    input  wire                   clk,
    input  wire                   reset_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::bus_rsp_t rsp_o
);

    import soc_bus_pkg::*;

    data_t     mem [RAM_DEPTH];  // contents survive reset
    ram_addr_t word_addr;
    logic      access;
    logic      ack_q;
    data_t     dat_q;

    assign word_addr = req_i.adr[RAM_ADDR_WIDTH-1:0];  // aliases above bit 11
    assign access    = req_i.stb && !ack_q && !reset_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.stb && !ack_q;  // one pulse per transfer
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[word_addr] <= req_i.dat;
            end
            dat_q <= mem[word_addr];
        end
    end

    assign rsp_o = '{ack: ack_q, dat: dat_q};

    // master must see a single-cycle ack
    assert property (@(posedge clk) disable iff (reset_i) ack_q |=> !ack_q)
        else $error("ram_wb8: ack held for two cycles");

endmodule

`default_nettype wire

/* sources.f */
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
verilog/bus_decoder.sv
ram/ram_wb8.sv
verilog/gpio_port.sv
timer/timer_wb8.sv
verilog/reset_gen.sv
verilog/soc_top.sv
verif/clock_gen.sv
verif/soc_top_tb.sv

/* timer/timer_wb8.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_wb8 (
    input  wire                   clk,
    input  wire                   reset_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::bus_rsp_t rsp_o,
    output logic                  irq_o
);

    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    logic   ack_q;
    data_t  dat_q;
    logic   count_en_q;  // ctrl bit 0
    logic   irq_en_q;    // ctrl bit 1
    logic   pending_q;
    count_t reload_q;
    count_t count_q;
    logic   access;
    logic   wr_en;
    logic   expire;

    assign access = req_i.stb && !ack_q;
    assign wr_en  = access && req_i.we;
    assign expire = count_en_q && (count_q == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q      <= 1'b0;
            count_en_q <= 1'b0;
            irq_en_q   <= 1'b0;
            pending_q  <= 1'b0;
            reload_q   <= '0;
            count_q    <= '0;
        end else begin
            ack_q <= access;

            // free running down-count with reload at zero
            if (expire) begin
                count_q <= reload_q;
            end else if (count_en_q) begin
                count_q <= count_q - 1'b1;
            end

            if (wr_en) begin
                case (req_i.adr[1:0])
                    TMR_CTRL: begin
                        count_en_q <= req_i.dat[0];
                        irq_en_q   <= req_i.dat[1];
                    end
                    TMR_STATUS: begin
                        if (req_i.dat[0]) begin
                            pending_q <= 1'b0;  // write one to clear
                        end
                    end
                    TMR_RELOAD_LO: begin
                        reload_q[7:0] <= req_i.dat;
                    end
                    TMR_RELOAD_HI: begin
                        reload_q[15:8] <= req_i.dat;
                        count_q        <= {req_i.dat, reload_q[7:0]};  // overrides the count
                    end
                    default: begin
                    end
                endcase
            end

            if (expire) begin
                pending_q <= 1'b1;  // a fresh expiry beats a clear
            end
        end
    end

    // register read back
    always_ff @(posedge clk) begin
        if (access) begin
            case (req_i.adr[1:0])
                TMR_CTRL:      dat_q <= {6'b0, irq_en_q, count_en_q};
                TMR_STATUS:    dat_q <= {7'b0, pending_q};
                TMR_RELOAD_LO: dat_q <= reload_q[7:0];
                default:       dat_q <= reload_q[15:8];
            endcase
        end
    end

    assign rsp_o = '{ack: ack_q, dat: dat_q};
    assign irq_o = pending_q && irq_en_q;

    assert property (@(posedge clk) irq_o |-> pending_q)
        else $error("timer_wb8: interrupt without pending");

endmodule

`default_nettype wire

/* verif/bus_trace.txt */
# op addr data : W write, R read and compare, T poll until equal
# op value : L irq level, E led level, P input pins; Y wait ready, I wait irq, S soft reset
Y
W 00000010 a5
R 00000010 a5
W 12345010 5a
R 00000010 5a
W 00000123 c3
W FFFFFC00 81
E 81
R FFFFFC00 81
P 3c
T FFFFFC01 3c
W FFFFF800 42
E 42
R FFFFF800 42
W FFFFFD02 0a
W FFFFFD03 00
R FFFFFD02 0a
W FFFFFD00 03
I
R FFFFFD01 01
W FFFFFD00 02
W FFFFFD01 01
L 0
R FFFFFD01 00
W FFFFFD00 01
T FFFFFD01 01
L 0
S
E 00
L 0
Y
R 00000010 5a
R 00000123 c3

/* verif/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk_o
);

    localparam time HALF_PERIOD = 10;  // 20 ns period

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* verif/soc_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb;

    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int  ACK_TIMEOUT  = 20;
    localparam int  WAIT_TIMEOUT = 100;  // ready and irq
    localparam int  POLL_LIMIT   = 50;
    localparam time DRIVE_DELAY  = 1;

    logic                  clk;
    logic                  reset_i;
    logic                  soft_reset_req;
    bus_req_t              bus_req;
    bus_rsp_t              bus_rsp;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] led;
    logic                  irq;
    logic                  ready;

    int               fd;
    int               code;
    int               op_count;
    logic [7:0]       op;
    addr_t            adr;
    logic [31:0]      val;
    logic [8*128-1:0] line_buf;

    clock_gen i_clock_gen (.clk_o(clk));

    soc_top i_soc_top (
        .clk              (clk),
        .reset_i          (reset_i),
        .soft_reset_req_i (soft_reset_req),
        .bus_req_i        (bus_req),
        .bus_rsp_o        (bus_rsp),
        .gpio_in_i        (gpio_in),
        .led_o            (led),
        .irq_o            (irq),
        .ready_o          (ready)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // one strobe/ack transfer, then an idle cycle
    task automatic transfer(input logic we, input addr_t a, input data_t d, output data_t q);
        int waited;
        waited  = 0;
        bus_req = '{stb: 1'b1, we: we, adr: a, dat: d};
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end while (!bus_rsp.ack && waited < ACK_TIMEOUT);
        if (!bus_rsp.ack) begin
            abort_run($sformatf("no acknowledge from address %h", a));
        end
        check_value("ack latency", waited, 1);
        q           = bus_rsp.dat;
        bus_req.stb = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic read_check(input addr_t a, input data_t exp);
        data_t q;
        transfer(1'b0, a, '0, q);
        check_value($sformatf("read data @%h", a), q, exp);
    endtask

    // read again until the value shows up
    task automatic poll_until(input addr_t a, input data_t exp);
        data_t q;
        int    tries;
        tries = 0;
        do begin
            transfer(1'b0, a, '0, q);
            tries++;
        end while (q !== exp && tries < POLL_LIMIT);
        if (q !== exp) begin
            abort_run($sformatf("address %h never read %h, last value %h", a, exp, q));
        end
    endtask

    task automatic wait_high(input bit pick_irq);
        int waited;
        waited = 0;
        while (!(pick_irq ? irq : ready) && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!(pick_irq ? irq : ready)) begin
            abort_run(pick_irq ? "irq_o did not rise in time" : "ready_o did not rise in time");
        end
    endtask

    // irq_o is raised first so the reset has to pull it down
    // one cycle request, the edge that sees it resets everything
    task automatic pulse_soft_reset();
        data_t ignored;
        transfer(1'b1, {IO_BASE_HI, TIMER_PAGE, 6'b0, TMR_CTRL}, 8'h03, ignored);
        wait_high(1'b1);
        soft_reset_req = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        soft_reset_req = 1'b0;
        check_value("ready_o", ready, 0);
        check_value("led_o", led, 0);
        check_value("irq_o", irq, 0);
    endtask

    task automatic read_fields(input int count);
        if (count == 2) begin
            code = $fscanf(fd, "%h %h", adr, val);
        end else begin
            code = $fscanf(fd, "%h", val);
        end
        if (code != count) begin
            abort_run($sformatf("malformed trace line for operation %c", op));
        end
    endtask

    initial begin
        data_t ignored;
        reset_i        = 1'b1;
        soft_reset_req = 1'b0;
        bus_req        = '0;
        gpio_in        = '0;
        op_count       = 0;
        fd = $fopen("verif/bus_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/bus_trace.txt");
        end
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code == 1) begin
                if (op != "#") op_count++;
                case (op)
                    "#": code = $fgets(line_buf, fd);  // comment line
                    "W": begin
                        read_fields(2);
                        transfer(1'b1, adr, val[7:0], ignored);
                    end
                    "R": begin
                        read_fields(2);
                        read_check(adr, val[7:0]);
                    end
                    "T": begin
                        read_fields(2);
                        poll_until(adr, val[7:0]);
                    end
                    "Y": wait_high(1'b0);
                    "I": wait_high(1'b1);
                    "L": begin
                        read_fields(1);
                        check_value("irq_o", irq, val);
                    end
                    "E": begin
                        read_fields(1);
                        check_value("led_o", led, val);
                    end
                    "P": begin
                        read_fields(1);
                        gpio_in = val[GPIO_WIDTH-1:0];
                    end
                    "S": pulse_soft_reset();
                    default: abort_run($sformatf("unknown trace operation %c", op));
                endcase
            end
        end
        $fclose(fd);

        if (op_count == 0) begin
            abort_run("trace held no operations");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  soc_bus_pkg::bus_req_t bus_req_i,
    output soc_bus_pkg::bus_req_t ram_req_o,
    output soc_bus_pkg::bus_req_t gpio_req_o,
    output soc_bus_pkg::bus_req_t timer_req_o,
    input  soc_bus_pkg::bus_rsp_t ram_rsp_i,
    input  soc_bus_pkg::bus_rsp_t gpio_rsp_i,
    input  soc_bus_pkg::bus_rsp_t timer_rsp_i,
    output soc_bus_pkg::bus_rsp_t bus_rsp_o
);

    import soc_map_pkg::*;

    logic  io_sel;
    logic  ram_sel;
    logic  gpio_sel;
    logic  timer_sel;
    page_t page;

    assign page = bus_req_i.adr[10:8];

    // upper 21 bits mark the I/O window, everything else is RAM
    assign io_sel    = (bus_req_i.adr[31:11] == IO_BASE_HI);
    assign ram_sel   = !io_sel;
    assign timer_sel = io_sel && (page == TIMER_PAGE);
    assign gpio_sel  = io_sel && (page != TIMER_PAGE);  // unused pages land here

    // fields fan out to everybody, only stb is steered
    always_comb begin
        ram_req_o       = bus_req_i;
        gpio_req_o      = bus_req_i;
        timer_req_o     = bus_req_i;
        ram_req_o.stb   = bus_req_i.stb && ram_sel;
        gpio_req_o.stb  = bus_req_i.stb && gpio_sel;
        timer_req_o.stb = bus_req_i.stb && timer_sel;
    end

    // response mux
    always_comb begin
        if (timer_sel) begin
            bus_rsp_o = timer_rsp_i;
        end else if (gpio_sel) begin
            bus_rsp_o = gpio_rsp_i;
        end else begin
            bus_rsp_o = ram_rsp_i;
        end
    end

    // never strobe two slaves at once
    always_comb begin
        assert ($onehot0({ram_req_o.stb, gpio_req_o.stb, timer_req_o.stb}))
            else $error("bus_decoder: more than one slave strobe");
    end

endmodule

`default_nettype wire

/* verilog/gpio_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
    input  wire                                  clk,
    input  wire                                  reset_i,
    input  soc_bus_pkg::bus_req_t                req_i,
    output soc_bus_pkg::bus_rsp_t                rsp_o,
    input  wire [soc_map_pkg::GPIO_WIDTH-1:0]    pins_i,
    output logic [soc_map_pkg::GPIO_WIDTH-1:0]   leds_o
);

    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    logic [GPIO_WIDTH-1:0] led_q;
    logic [GPIO_WIDTH-1:0] pin_meta_q;
    logic [GPIO_WIDTH-1:0] pin_sync_q;
    logic                  ack_q;
    data_t                 dat_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            led_q <= '0;
        end else begin
            ack_q <= req_i.stb && !ack_q;
            if (req_i.stb && !ack_q && req_i.we && !req_i.adr[0]) begin
                led_q <= req_i.dat;  // offset 1 is read only
            end
        end
    end

    // two-flop synchronizer on the pins
    always_ff @(posedge clk) begin
        pin_meta_q <= pins_i;
        pin_sync_q <= pin_meta_q;
    end

    always_ff @(posedge clk) begin
        if (req_i.stb && !ack_q) begin
            dat_q <= req_i.adr[0] ? pin_sync_q : led_q;
        end
    end

    assign rsp_o  = '{ack: ack_q, dat: dat_q};
    assign leds_o = led_q;

endmodule

`default_nettype wire

/* verilog/reset_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
    input  wire  clk,
    input  wire  reset_i,
    input  wire  soft_reset_req_i,
    output logic sys_reset_o,
    output logic ready_o
);

    import soc_map_pkg::*;

    hold_t hold_q;
    logic  req;
    logic  ready_q;

    assign req = reset_i || soft_reset_req_i;

    // restart on every request, the ready flop supplies the last cycle
    always_ff @(posedge clk) begin
        if (req) begin
            hold_q <= HOLD_WIDTH'(RESET_HOLD - 1);
        end else if (hold_q != '0) begin
            hold_q <= hold_q - 1'b1;
        end
    end

    assign sys_reset_o = req || (hold_q != '0);

    always_ff @(posedge clk) begin
        ready_q <= !sys_reset_o;
    end

    assign ready_o = ready_q;

endmodule

`default_nettype wire

/* verilog/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  wire                                clk,
    input  wire                                reset_i,
    input  wire                                soft_reset_req_i,
    input  soc_bus_pkg::bus_req_t              bus_req_i,
    output soc_bus_pkg::bus_rsp_t              bus_rsp_o,
    input  wire [soc_map_pkg::GPIO_WIDTH-1:0]  gpio_in_i,
    output logic [soc_map_pkg::GPIO_WIDTH-1:0] led_o,
    output logic                               irq_o,
    output logic                               ready_o
);

    import soc_bus_pkg::*;

    logic     sys_reset;
    bus_req_t ram_req;
    bus_req_t gpio_req;
    bus_req_t timer_req;
    bus_rsp_t ram_rsp;
    bus_rsp_t gpio_rsp;
    bus_rsp_t timer_rsp;

    reset_gen i_reset_gen (
        .clk              (clk),
        .reset_i          (reset_i),
        .soft_reset_req_i (soft_reset_req_i),
        .sys_reset_o      (sys_reset),
        .ready_o          (ready_o)
    );

    // master request goes straight in, slaves hold off during reset
    bus_decoder i_bus_decoder (
        .bus_req_i   (bus_req_i),
        .ram_req_o   (ram_req),
        .gpio_req_o  (gpio_req),
        .timer_req_o (timer_req),
        .ram_rsp_i   (ram_rsp),
        .gpio_rsp_i  (gpio_rsp),
        .timer_rsp_i (timer_rsp),
        .bus_rsp_o   (bus_rsp_o)
    );

    ram_wb8 i_ram (
        .clk     (clk),
        .reset_i (sys_reset),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    gpio_port i_gpio (
        .clk     (clk),
        .reset_i (sys_reset),
        .req_i   (gpio_req),
        .rsp_o   (gpio_rsp),
        .pins_i  (gpio_in_i),
        .leds_o  (led_o)
    );

    timer_wb8 i_timer (
        .clk     (clk),
        .reset_i (sys_reset),
        .req_i   (timer_req),
        .rsp_o   (timer_rsp),
        .irq_o   (irq_o)
    );

endmodule

`default_nettype wire
